//--- sim/tracker_vectors.txt
// words 0-31: frame-buffer image as rrggbb, 8 pixels per row, row 0 first
// words 32-37: mask cases as CTRL word and REG_COM word (x 10:0, y 25:16, valid 31)
// words 38-41: CTRL words for readback, no match, camera view and crosshair view
102030 E01838 203010 302820 401C28 502434 60143C 2010D0
0C0C0C 183010 90203C 3C3C3C 7F3F40 481020 241A50 123456
0828F0 2C2C2C 341C44 0A0B0C 307020 6A306A 222222 5A0A5A
2E3F0E 11A022 4C1830 204010 383838 159F25 7E267E 090909
// red 80 to FF hits two pixels, centre x 11 y 1
0004FF80 8001000B
// green 40 to 9F hits three pixels including both bounds, centre x 6 y 5
00059F40 80050006
// blue C0 to FF hits two pixels, centre x 7 y 2
0006FFC0 80020007
// readback word, crosshair view on green 3C to A5
0009A53C
// lower above upper
000000FF
// camera view
0000FF80
// crosshair view on blue C0 to FF
000AFFC0

//--- sources.f
rtl/video_pkg.sv
rtl/regs_pkg.sv
rtl/video_timing.sv
rtl/pixel_classifier.sv
rtl/seq_divider.sv
rtl/centroid.sv
rtl/overlay_mux.sv
rtl/wb_config_regs.sv
rtl/pixel_tracker_top.sv
sim/tb_pixel_tracker.sv

//--- Bender.yml
package:
  name: pixel_tracker

sources:
  - rtl/video_pkg.sv
  - rtl/regs_pkg.sv
  - rtl/video_timing.sv
  - rtl/pixel_classifier.sv
  - rtl/seq_divider.sv
  - rtl/centroid.sv
  - rtl/overlay_mux.sv
  - rtl/wb_config_regs.sv
  - rtl/pixel_tracker_top.sv
  - target: simulation
    files:
      - sim/tb_pixel_tracker.sv

//--- sim/tb_pixel_tracker.sv
module tb_pixel_tracker
    import video_pkg::*;
    import regs_pkg::*;
();

    // small raster so a frame is only 240 cycles
    localparam int H_ACTIVE = 16;
    localparam int H_FRONT = 2;
    localparam int H_SYNC = 3;
    localparam int H_TOTAL = 24;
    localparam int V_ACTIVE = 8;
    localparam int V_FRONT = 1;
    localparam int V_SYNC = 1;
    localparam int V_TOTAL = 10;
    localparam int FB_W = 8;
    localparam int FB_H = 4;
    localparam int SCALE_SHIFT = 1;
    localparam int SUM_W = 16;
    localparam int ADDR_W = $clog2(FB_W * FB_H);
    localparam int FRAME_LIMIT = 2 * H_TOTAL * V_TOTAL;
    localparam int ACK_LIMIT = 16;
    // raster position to video output
    localparam int PIPE_DEPTH = 4;

    logic              clk_pixel = 1'b0;
    logic              sys_rst_pixel;
    wb_req_t           wb_req;
    wb_rsp_t           wb_rsp;
    logic [ADDR_W-1:0] fb_addr;
    logic              fb_addr_ok;
    rgb_t              fb_pixel;
    video_out_t        video;

    // image, mask cases, control words
    logic [31:0]       vec_mem [0:41];
    rgb_t              fb_mem [0:FB_W*FB_H-1];
    logic [ADDR_W-1:0] addr_q;
    // fetch-valid flag of the positions now in stages 2 to 4
    logic [2:0]        ok_hist;
    logic [31:0]       lfsr;
    com_t              cross_com;
    int                checks;
    int                errors;
    int                timeouts;

    always #2 clk_pixel = ~clk_pixel;

    pixel_tracker_top #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_TOTAL(H_TOTAL),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_TOTAL(V_TOTAL),
        .FB_W(FB_W), .FB_H(FB_H), .SCALE_SHIFT(SCALE_SHIFT), .SUM_W(SUM_W)
    ) DUT (
        .clk_pixel(clk_pixel), .sys_rst_pixel(sys_rst_pixel), .wb_req(wb_req),
        .wb_rsp(wb_rsp), .fb_addr(fb_addr), .fb_addr_ok(fb_addr_ok),
        .fb_pixel(fb_pixel), .video(video)
    );

    // frame-buffer memory, word comes back one cycle after its address
    always @(negedge clk_pixel) begin
        fb_pixel <= fb_mem[addr_q];
        addr_q   <= fb_addr;
        ok_hist  <= {ok_hist[1:0], fb_addr_ok};
    end

    task automatic report_and_stop();
        $display("checks %0d, value errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // 0 to 3 idle cycles, one lfsr step per bit
    task automatic idle_gap();
        int gap;
        gap = 0;
        for (int i = 0; i < 2; i++) begin
            gap = (gap << 1) | int'(lfsr[0]);
            lfsr = lfsr_next(lfsr);
        end
        repeat (gap) @(negedge clk_pixel);
    endtask

    function automatic com_t word_to_com(input logic [31:0] w);
        return '{x: w[X_W-1:0], y: w[16 +: Y_W], valid: w[31]};
    endfunction

    // display area covered by the scaled frame buffer
    function automatic logic in_fetch_window(input int x, input int y);
        return (x < (FB_W << SCALE_SHIFT)) && (y < (FB_H << SCALE_SHIFT));
    endfunction

    // hsync, vsync, active, new_frame as the low four bits
    function automatic logic [31:0] expected_flags(input int x, input int y);
        logic hs;
        logic vs;
        logic act;
        logic nf;
        hs  = (x >= H_ACTIVE + H_FRONT) && (x < H_ACTIVE + H_FRONT + H_SYNC);
        vs  = (y >= V_ACTIVE + V_FRONT) && (y < V_ACTIVE + V_FRONT + V_SYNC);
        act = (x < H_ACTIVE) && (y < V_ACTIVE);
        nf  = (x == 0) && (y == 0);
        return 32'({hs, vs, act, nf});
    endfunction

    // mirrored, 2x2 scaled fetch, black outside the frame-buffer window
    function automatic rgb_t camera_pixel(input int x, input int y);
        if (!in_fetch_window(x, y)) begin
            return RGB_BLACK;
        end
        return fb_mem[(FB_W - 1 - (x >> SCALE_SHIFT)) + FB_W * (y >> SCALE_SHIFT)];
    endfunction

    function automatic rgb_t expected_pixel(input int x, input int y, input cfg_t cfg,
                                            input com_t com);
        rgb_t       cam;
        logic [7:0] level;
        logic       hit;
        if (x >= H_ACTIVE || y >= V_ACTIVE) begin
            return RGB_BLACK;
        end
        cam = camera_pixel(x, y);
        case (cfg.channel)
            RED_CH:   level = cam.red;
            GREEN_CH: level = cam.green;
            default:  level = cam.blue;
        endcase
        hit = in_fetch_window(x, y) && level >= cfg.lower && level <= cfg.upper;
        case (cfg.view)
            MASK_VIEW:      return hit ? RGB_WHITE : RGB_BLACK;
            CROSSHAIR_VIEW: return (com.valid && (x == com.x || y == com.y)) ? RGB_WHITE : cam;
            default:        return cam;
        endcase
    endfunction

    task automatic check_pixel(input string name, input rgb_t got, input rgb_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_com(input string name, input com_t got, input com_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s got x=%0d y=%0d valid=%b expected x=%0d y=%0d valid=%b",
                     $time, name, got.x, got.y, got.valid, exp.x, exp.y, exp.valid);
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // one classic cycle, request held until ack
    task automatic bus_access(input logic we, input logic [1:0] adr, input logic [31:0] wdat,
                              output logic [31:0] rdat);
        int n;
        idle_gap();
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        n = 0;
        do begin
            @(negedge clk_pixel);
            n++;
        end while (!wb_rsp.ack && n < ACK_LIMIT);
        rdat = wb_rsp.dat;
        wb_req = '0;
        if (!wb_rsp.ack) begin
            timeouts++;
            $display("register slave gave no ack for address %0d", adr);
            report_and_stop();
        end
    endtask

    task automatic bus_read(input logic [1:0] adr, output logic [31:0] rdat);
        bus_access(1'b0, adr, 32'h0, rdat);
    endtask

    task automatic bus_write(input logic [1:0] adr, input logic [31:0] wdat);
        logic [31:0] ignored;
        bus_access(1'b1, adr, wdat, ignored);
    endtask

    task automatic set_config(input logic [31:0] ctrl);
        bus_write(REG_CTRL, ctrl);
        // old setting may still sit in the pipeline registers
        repeat (PIPE_DEPTH) @(negedge clk_pixel);
    endtask

    // always moves at least one cycle, stops on x=0 y=0 at the output
    task automatic await_frame_start();
        int n;
        n = 0;
        do begin
            @(negedge clk_pixel);
            n++;
        end while (!video.raster.new_frame && n < FRAME_LIMIT);
        if (!video.raster.new_frame) begin
            timeouts++;
            $display("video output showed no frame start within %0d cycles", FRAME_LIMIT);
            report_and_stop();
        end
    endtask

    // starts on a frame start, checks every position up to the next one
    task automatic check_frame(input logic [31:0] ctrl);
        cfg_t cfg;
        int   n;
        int   x;
        int   y;
        cfg = cfg_t'(ctrl[19:0]);
        n = 0;
        do begin
            x = video.raster.x;
            y = video.raster.y;
            check_pixel($sformatf("video.pixel at x=%0d y=%0d", x, y),
                        video.pixel, expected_pixel(x, y, cfg, cross_com));
            check_word($sformatf("video flags at x=%0d y=%0d", x, y),
                       32'({video.raster.hsync, video.raster.vsync,
                            video.raster.active, video.raster.new_frame}),
                       expected_flags(x, y));
            check_word($sformatf("fb_addr_ok for x=%0d y=%0d", x, y),
                       32'(ok_hist[2]), 32'(in_fetch_window(x, y)));
            @(negedge clk_pixel);
            n++;
        end while (!video.raster.new_frame && n < FRAME_LIMIT);
        if (!video.raster.new_frame) begin
            timeouts++;
            $display("video frame did not end within %0d cycles", FRAME_LIMIT);
            report_and_stop();
        end
    endtask

    initial begin
        logic [31:0] word;
        logic [31:0] word_b;
        logic [31:0] count_a;
        logic [31:0] count_b;
        sys_rst_pixel = 1'b1;
        wb_req = '0;
        fb_pixel = RGB_BLACK;
        addr_q = '0;
        ok_hist = '0;
        lfsr = 32'hb84c;
        cross_com = '0;
        checks = 0;
        errors = 0;
        timeouts = 0;
        $readmemh("sim/tracker_vectors.txt", vec_mem);
        if ($isunknown(vec_mem[41])) begin
            errors++;
            $display("vector file sim/tracker_vectors.txt is missing or too short");
            report_and_stop();
        end
        for (int i = 0; i < FB_W * FB_H; i++) begin
            fb_mem[i] = rgb_t'(vec_mem[i][23:0]);
        end
        repeat (8) @(negedge clk_pixel);
        sys_rst_pixel = 1'b0;

        // register access, well before the first centroid result
        bus_read(REG_CTRL, word);
        check_word("REG_CTRL after reset", word, 32'(CFG_RESET));
        bus_write(REG_CTRL, vec_mem[38]);
        bus_read(REG_CTRL, word);
        check_word("REG_CTRL readback", word, vec_mem[38]);
        bus_read(REG_COM, word);
        bus_write(REG_COM, 32'hFFFF_FFFF);
        bus_read(REG_COM, word_b);
        check_word("REG_COM after write", word_b, word);

        // camera view
        set_config(vec_mem[40]);
        await_frame_start();
        check_frame(vec_mem[40]);

        // mask view per channel, then the centroid of the checked frame
        for (int c = 0; c < 3; c++) begin
            set_config(vec_mem[32 + 2 * c]);
            await_frame_start();
            check_frame(vec_mem[32 + 2 * c]);
            // dividers finish early in the following frame
            await_frame_start();
            bus_read(REG_COM, word);
            check_com("REG_COM", word_to_com(word), word_to_com(vec_mem[33 + 2 * c]));
            bus_read(REG_FRAMES, count_a);
            await_frame_start();
            bus_read(REG_FRAMES, count_b);
            check_word("REG_FRAMES step", count_b, count_a + 1);
        end

        // crosshair through the blue result
        cross_com = word_to_com(vec_mem[37]);
        set_config(vec_mem[41]);
        await_frame_start();
        check_frame(vec_mem[41]);

        // nothing matches, result and frame count stay put
        set_config(vec_mem[39]);
        await_frame_start();
        await_frame_start();
        bus_read(REG_COM, word);
        bus_read(REG_FRAMES, count_a);
        await_frame_start();
        await_frame_start();
        bus_read(REG_COM, word_b);
        bus_read(REG_FRAMES, count_b);
        check_com("REG_COM held", word_to_com(word_b), word_to_com(word));
        check_word("REG_COM valid bit", 32'(word_b[31]), 32'd1);
        check_word("REG_FRAMES held", count_b, count_a);

        report_and_stop();
    end

endmodule

//--- rtl/pixel_tracker_top.sv
module pixel_tracker_top
    import video_pkg::*;
    import regs_pkg::*;
#(
    parameter  int H_ACTIVE = 1280,
    parameter  int H_FRONT = 110,
    parameter  int H_SYNC = 40,
    parameter  int H_TOTAL = 1650,
    parameter  int V_ACTIVE = 720,
    parameter  int V_FRONT = 5,
    parameter  int V_SYNC = 5,
    parameter  int V_TOTAL = 750,
    parameter  int FB_W = 320,
    parameter  int FB_H = 180,
    parameter  int SCALE_SHIFT = 2,
    parameter  int SUM_W = 32,
    localparam int FB_ADDR_W = $clog2(FB_W * FB_H)
) (
    input  logic                 clk_pixel,
    input  logic                 sys_rst_pixel,
    input  wb_req_t              wb_req,
    output wb_rsp_t              wb_rsp,
    output logic [FB_ADDR_W-1:0] fb_addr,
    output logic                 fb_addr_ok,
    input  rgb_t                 fb_pixel,
    output video_out_t           video
);

    raster_t raster;
    raster_t raster_cls;
    rgb_t    pixel_cls;
    logic    mask;
    cfg_t    cfg;
    com_t    com;
    logic    com_done;

    // stage 0
    video_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_TOTAL(H_TOTAL),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_TOTAL(V_TOTAL)
    ) u_timing (
        .clk_pixel(clk_pixel), .sys_rst_pixel(sys_rst_pixel), .raster(raster)
    );

    // stages 1 to 3, external memory sits between 1 and 2
    pixel_classifier #(.FB_W(FB_W), .FB_H(FB_H), .SCALE_SHIFT(SCALE_SHIFT)) u_classifier (
        .clk_pixel(clk_pixel), .sys_rst_pixel(sys_rst_pixel), .raster(raster), .cfg(cfg),
        .fb_addr(fb_addr), .fb_addr_ok(fb_addr_ok), .fb_pixel(fb_pixel),
        .raster_cls(raster_cls), .pixel_cls(pixel_cls), .mask(mask)
    );

    centroid #(.SUM_W(SUM_W)) u_centroid (
        .clk_pixel(clk_pixel), .sys_rst_pixel(sys_rst_pixel), .raster_cls(raster_cls),
        .mask(mask), .com(com), .com_done(com_done)
    );

    // stage 4
    overlay_mux u_overlay (
        .clk_pixel(clk_pixel), .sys_rst_pixel(sys_rst_pixel), .raster_cls(raster_cls),
        .pixel_cls(pixel_cls), .mask(mask), .com(com), .view(cfg.view), .video(video)
    );

    wb_config_regs u_regs (
        .clk_pixel(clk_pixel), .sys_rst_pixel(sys_rst_pixel), .wb_req(wb_req),
        .wb_rsp(wb_rsp), .com(com), .com_done(com_done), .cfg(cfg)
    );

endmodule

//--- rtl/wb_config_regs.sv
module wb_config_regs
    import video_pkg::*;
    import regs_pkg::*;
(
    input  logic    clk_pixel,
    input  logic    sys_rst_pixel,
    input  wb_req_t wb_req,
    output wb_rsp_t wb_rsp,
    input  com_t    com,
    input  logic    com_done,
    output cfg_t    cfg
);

    logic        ack;
    logic [31:0] rd_dat;
    logic [31:0] rd_next;
    logic [31:0] com_word;
    logic [15:0] frames;
    logic        hit;

    // new request only, a held one already got its ack
    assign hit = wb_req.cyc && wb_req.stb && !ack;

    always_comb begin
        com_word = '0;
        com_word[X_W-1:0] = com.x;
        com_word[16 +: Y_W] = com.y;
        com_word[31] = com.valid;
    end

    always_comb begin
        case (wb_req.adr)
            REG_CTRL:   rd_next = 32'(cfg);
            REG_COM:    rd_next = com_word;
            REG_FRAMES: rd_next = {16'h0000, frames};
            default:    rd_next = '0;
        endcase
    end

    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            ack    <= 1'b0;
            cfg    <= CFG_RESET;
            frames <= '0;
        end else begin
            ack <= hit;
            // only CTRL is writable, the rest take the ack and drop the data
            if (hit && wb_req.we && (wb_req.adr == REG_CTRL)) begin
                cfg <= cfg_t'(wb_req.dat[$bits(cfg_t)-1:0]);
            end
            if (com_done) begin
                frames <= frames + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (hit) begin
            rd_dat <= rd_next;
        end
    end

    assign wb_rsp = '{ack: ack, dat: rd_dat};

    single_cycle_ack: assert property (
        @(posedge clk_pixel) disable iff (sys_rst_pixel) ack |=> !ack
    );

endmodule

//--- rtl/overlay_mux.sv
module overlay_mux
    import video_pkg::*;
    import regs_pkg::*;
(
    input  logic       clk_pixel,
    input  logic       sys_rst_pixel,
    input  raster_t    raster_cls,
    input  rgb_t       pixel_cls,
    input  logic       mask,
    input  com_t       com,
    input  view_t      view,
    output video_out_t video
);

    logic on_cross;
    rgb_t pixel_next;

    // crosshair lines through the last centre of mass
    assign on_cross = com.valid && ((raster_cls.x == com.x) || (raster_cls.y == com.y));

    always_comb begin
        case (view)
            MASK_VIEW:      pixel_next = mask ? RGB_WHITE : RGB_BLACK;
            CROSSHAIR_VIEW: pixel_next = on_cross ? RGB_WHITE : pixel_cls;
            default:        pixel_next = pixel_cls;
        endcase
        // blanking
        if (!raster_cls.active) begin
            pixel_next = RGB_BLACK;
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            video.raster <= '0;
        end else begin
            video.raster <= raster_cls;
        end
    end

    always_ff @(posedge clk_pixel) begin
        video.pixel <= pixel_next;
    end

endmodule

//--- rtl/centroid.sv
module centroid
    import video_pkg::*;
    import regs_pkg::*;
#(
    parameter int SUM_W = 32
) (
    input  logic    clk_pixel,
    input  logic    sys_rst_pixel,
    input  raster_t raster_cls,
    input  logic    mask,
    output com_t    com,
    output logic    com_done
);

    logic [SUM_W-1:0] sum_x;
    logic [SUM_W-1:0] sum_y;
    logic [SUM_W-1:0] hits;
    logic [SUM_W-1:0] quo_x;
    logic [SUM_W-1:0] quo_y;
    logic             done_x;
    logic             done_y;
    logic             start;

    // sums still hold the frame just ended when new_frame shows up
    assign start = raster_cls.new_frame && (hits != '0);

    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            sum_x <= '0;
            sum_y <= '0;
            hits  <= '0;
        end else if (raster_cls.new_frame) begin
            // first pixel of the frame opens the new sums
            sum_x <= mask ? SUM_W'(raster_cls.x) : '0;
            sum_y <= mask ? SUM_W'(raster_cls.y) : '0;
            hits  <= SUM_W'(mask);
        end else if (mask) begin
            sum_x <= sum_x + SUM_W'(raster_cls.x);
            sum_y <= sum_y + SUM_W'(raster_cls.y);
            hits  <= hits + 1'b1;
        end
    end

    seq_divider #(.SUM_W(SUM_W)) div_x (
        .clk_pixel    (clk_pixel),
        .sys_rst_pixel(sys_rst_pixel),
        .start        (start),
        .dividend     (sum_x),
        .divisor      (hits),
        .quotient     (quo_x),
        .done         (done_x)
    );

    seq_divider #(.SUM_W(SUM_W)) div_y (
        .clk_pixel    (clk_pixel),
        .sys_rst_pixel(sys_rst_pixel),
        .start        (start),
        .dividend     (sum_y),
        .divisor      (hits),
        .quotient     (quo_y),
        .done         (done_y)
    );

    // result held until the next frame with hits
    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            com      <= '0;
            com_done <= 1'b0;
        end else begin
            com_done <= done_x && done_y;
            if (done_x && done_y) begin
                com <= '{x: quo_x[X_W-1:0], y: quo_y[Y_W-1:0], valid: 1'b1};
            end
        end
    end

endmodule

//--- rtl/seq_divider.sv
module seq_divider #(
    parameter int SUM_W = 32
) (
    input  logic             clk_pixel,
    input  logic             sys_rst_pixel,
    input  logic             start,
    input  logic [SUM_W-1:0] dividend,
    input  logic [SUM_W-1:0] divisor,
    output logic [SUM_W-1:0] quotient,
    output logic             done
);

    localparam int CNT_W = $clog2(SUM_W + 1);

    logic             busy;
    logic [CNT_W-1:0] steps;
    logic [SUM_W-1:0] rem;
    logic [SUM_W-1:0] div_q;
    logic [SUM_W:0]   shifted;
    logic [SUM_W:0]   trial;

    // bring in the next dividend bit, then try the subtraction
    assign shifted = {rem, quotient[SUM_W-1]};
    assign trial = shifted - {1'b0, div_q};

    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            busy  <= 1'b0;
            done  <= 1'b0;
            steps <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy  <= 1'b1;
                steps <= CNT_W'(SUM_W);
            end else if (busy) begin
                steps <= steps - 1'b1;
                // last quotient bit lands here
                if (steps == CNT_W'(1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // datapath, quotient register doubles as the dividend shifter
    always_ff @(posedge clk_pixel) begin
        if (start) begin
            quotient <= dividend;
            div_q    <= divisor;
            rem      <= '0;
        end else if (busy) begin
            if (!trial[SUM_W]) begin
                rem      <= trial[SUM_W-1:0];
                quotient <= {quotient[SUM_W-2:0], 1'b1};
            end else begin
                rem      <= shifted[SUM_W-1:0];
                quotient <= {quotient[SUM_W-2:0], 1'b0};
            end
        end
    end

    no_start_while_busy: assert property (
        @(posedge clk_pixel) disable iff (sys_rst_pixel) start |-> !busy
    );

endmodule

//--- rtl/pixel_classifier.sv
module pixel_classifier
    import video_pkg::*;
    import regs_pkg::*;
#(
    parameter  int FB_W = 320,
    parameter  int FB_H = 180,
    parameter  int SCALE_SHIFT = 2,
    localparam int ADDR_W = $clog2(FB_W * FB_H)
) (
    input  logic              clk_pixel,
    input  logic              sys_rst_pixel,
    input  raster_t           raster,
    input  cfg_t              cfg,
    output logic [ADDR_W-1:0] fb_addr,
    output logic              fb_addr_ok,
    input  rgb_t              fb_pixel,
    output raster_t           raster_cls,
    output rgb_t              pixel_cls,
    output logic              mask
);

    // display area covered by the scaled frame buffer
    localparam logic [X_W-1:0] X_LIMIT = X_W'(FB_W << SCALE_SHIFT);
    localparam logic [Y_W-1:0] Y_LIMIT = Y_W'(FB_H << SCALE_SHIFT);
    localparam logic [ADDR_W-1:0] COL_LAST = ADDR_W'(FB_W - 1);
    localparam logic [ADDR_W-1:0] ROW_PITCH = ADDR_W'(FB_W);

    raster_t           raster_s1;
    raster_t           raster_s2;
    logic              ok_s2;
    logic [ADDR_W-1:0] col;
    logic [ADDR_W-1:0] row;
    logic [7:0]        level;

    // mirrored column, plain row
    assign col = COL_LAST - ADDR_W'(raster.x >> SCALE_SHIFT);
    assign row = ADDR_W'(raster.y >> SCALE_SHIFT);

    // channel under test, taken from the returned pixel
    always_comb begin
        case (cfg.channel)
            RED_CH:   level = fb_pixel.red;
            GREEN_CH: level = fb_pixel.green;
            default:  level = fb_pixel.blue;
        endcase
    end

    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            fb_addr_ok <= 1'b0;
            raster_s1  <= '0;
            raster_s2  <= '0;
            ok_s2      <= 1'b0;
            raster_cls <= '0;
            mask       <= 1'b0;
        end else begin
            // stage 1, address goes out
            fb_addr_ok <= (raster.x < X_LIMIT) && (raster.y < Y_LIMIT);
            raster_s1  <= raster;
            // stage 2, memory answers for raster_s2
            raster_s2  <= raster_s1;
            ok_s2      <= fb_addr_ok;
            // stage 3, classify
            raster_cls <= raster_s2;
            mask       <= ok_s2 && raster_s2.active
                          && (level >= cfg.lower) && (level <= cfg.upper);
        end
    end

    always_ff @(posedge clk_pixel) begin
        fb_addr   <= col + ROW_PITCH * row;
        // outside the fetch window the memory word is meaningless
        pixel_cls <= ok_s2 ? fb_pixel : RGB_BLACK;
    end

endmodule

//--- rtl/video_timing.sv
module video_timing
    import video_pkg::*;
#(
    parameter int H_ACTIVE = 1280,
    parameter int H_FRONT = 110,
    parameter int H_SYNC = 40,
    parameter int H_TOTAL = 1650,
    parameter int V_ACTIVE = 720,
    parameter int V_FRONT = 5,
    parameter int V_SYNC = 5,
    parameter int V_TOTAL = 750
) (
    input  logic    clk_pixel,
    input  logic    sys_rst_pixel,
    output raster_t raster
);

    localparam logic [X_W-1:0] H_LAST = X_W'(H_TOTAL - 1);
    localparam logic [Y_W-1:0] V_LAST = Y_W'(V_TOTAL - 1);
    localparam logic [X_W-1:0] H_ACT = X_W'(H_ACTIVE);
    localparam logic [Y_W-1:0] V_ACT = Y_W'(V_ACTIVE);
    // sync windows start after the front porch
    localparam logic [X_W-1:0] HS_START = X_W'(H_ACTIVE + H_FRONT);
    localparam logic [X_W-1:0] HS_END = X_W'(H_ACTIVE + H_FRONT + H_SYNC);
    localparam logic [Y_W-1:0] VS_START = Y_W'(V_ACTIVE + V_FRONT);
    localparam logic [Y_W-1:0] VS_END = Y_W'(V_ACTIVE + V_FRONT + V_SYNC);

    logic [X_W-1:0] x_next;
    logic [Y_W-1:0] y_next;

    // next scan position, wraps at the totals
    always_comb begin
        x_next = raster.x + 1'b1;
        y_next = raster.y;
        if (raster.x == H_LAST) begin
            x_next = '0;
            y_next = (raster.y == V_LAST) ? '0 : raster.y + 1'b1;
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            // park on the last position so the first output is 0,0 with new_frame
            raster <= '{x: H_LAST, y: V_LAST, default: 1'b0};
        end else begin
            raster.x         <= x_next;
            raster.y         <= y_next;
            raster.active    <= (x_next < H_ACT) && (y_next < V_ACT);
            raster.hsync     <= (x_next >= HS_START) && (x_next < HS_END);
            raster.vsync     <= (y_next >= VS_START) && (y_next < VS_END);
            raster.new_frame <= (x_next == '0) && (y_next == '0);
        end
    end

    x_in_range: assert property (
        @(posedge clk_pixel) disable iff (sys_rst_pixel) raster.x < X_W'(H_TOTAL)
    );

endmodule

//--- rtl/regs_pkg.sv
package regs_pkg;

    import video_pkg::*;

    // wishbone classic, word addressed
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [1:0]  adr;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    localparam logic [1:0] REG_CTRL = 2'd0;
    localparam logic [1:0] REG_COM = 2'd1;
    localparam logic [1:0] REG_FRAMES = 2'd2;

    // field order matches the CTRL word, lower sits in bits 7:0
    typedef struct packed {
        view_t      view;
        channel_t   channel;
        logic [7:0] upper;
        logic [7:0] lower;
    } cfg_t;

    localparam cfg_t CFG_RESET = '{view: CAMERA_VIEW, channel: RED_CH, upper: 8'hFF, lower: 8'h80};

    typedef struct packed {
        logic [X_W-1:0] x;
        logic [Y_W-1:0] y;
        logic           valid;
    } com_t;

endpackage

//--- rtl/video_pkg.sv
package video_pkg;

    // coordinate widths, sized for 1280x720 timing
    localparam int X_W = 11;
    localparam int Y_W = 10;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    // one scan position with its timing flags
    typedef struct packed {
        logic [X_W-1:0] x;
        logic [Y_W-1:0] y;
        logic           hsync;
        logic           vsync;
        logic           active;
        logic           new_frame;
    } raster_t;

    typedef struct packed {
        raster_t raster;
        rgb_t    pixel;
    } video_out_t;

    typedef enum logic [1:0] {CAMERA_VIEW, MASK_VIEW, CROSSHAIR_VIEW} view_t;
    typedef enum logic [1:0] {RED_CH, GREEN_CH, BLUE_CH} channel_t;

    localparam rgb_t RGB_BLACK = '{red: 8'h00, green: 8'h00, blue: 8'h00};
    localparam rgb_t RGB_WHITE = '{red: 8'hFF, green: 8'hFF, blue: 8'hFF};

endpackage
